//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := i2c_master_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/i2c_master_tb.sv
// I2C master testbench
`timescale 1ns/1ns
`default_nettype none

module i2c_master_tb;

    localparam logic [i2c_master_pkg::ADDR_W-1:0] SLAVE_ADDR = 7'h50;
    localparam int                                TIMEOUT    = 200;   // Cycles per transfer

    logic                                I2C_Clk_In;
    logic                                Reset_In;
    logic                                start_in;
    logic                                burst_in;
    logic [i2c_master_pkg::BURST_W-1:0]  burst_len_in;
    logic                                read_in;
    logic [i2c_master_pkg::ADDR_W-1:0]   slave_addr_in;
    i2c_master_pkg::byte_t               reg_addr_in;
    i2c_master_pkg::byte_t               data_in;
    wire                                 busy;
    wire                                 data_req;
    wire  [i2c_master_pkg::BYTE_W-1:0]   data_out;
    wire                                 rd_valid;
    wire                                 nack_error;
    wire                                 sda_drive_low;
    wire                                 scl;
    wire                                 slave_pull_low;
    wire                                 sda;

    i2c_master_pkg::byte_t wr_queue [$];                // Handed out on data_req
    i2c_master_pkg::byte_t rd_queue [$];                // Collected on rd_valid
    int                    req_count;
    int                    valid_count;
    int                    errors;
    int                    tests;
    int                    seed;

    assign sda = !(sda_drive_low || slave_pull_low);    // Wired AND

    i2c_master UUT (
        .I2C_Clk_In    (I2C_Clk_In),
        .Reset_In      (Reset_In),
        .start_in      (start_in),
        .burst_in      (burst_in),
        .burst_len_in  (burst_len_in),
        .read_in       (read_in),
        .slave_addr_in (slave_addr_in),
        .reg_addr_in   (reg_addr_in),
        .data_in       (data_in),
        .busy          (busy),
        .data_req      (data_req),
        .data_out      (data_out),
        .rd_valid      (rd_valid),
        .nack_error    (nack_error),
        .sda_in        (sda),
        .sda_drive_low (sda_drive_low),
        .scl           (scl)
    );

    i2c_slave_model #(.DEV_ADDR(SLAVE_ADDR)) u_slave (
        .scl      (scl),
        .sda      (sda),
        .pull_low (slave_pull_low)
    );

    initial
    begin
        I2C_Clk_In = 1'b0;
        forever #4 I2C_Clk_In = ~I2C_Clk_In;
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_run();
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("%-14s %s", name, (errors == err0) ? "ok" : "with errors");
    endtask

    // Runs one transaction and counts strobes until busy falls
    task automatic run_transfer(input logic rd, input logic burst,
                                input logic [i2c_master_pkg::BURST_W-1:0] len,
                                input logic [i2c_master_pkg::ADDR_W-1:0] addr,
                                input i2c_master_pkg::byte_t reg_a);
        int   cycles;
        logic done;
        logic req_seen;
        cycles      = 0;
        done        = 1'b0;
        req_count   = 0;
        valid_count = 0;
        rd_queue.delete();
        @(negedge I2C_Clk_In);
        start_in      <= 1'b1;
        burst_in      <= burst;
        burst_len_in  <= len;
        read_in       <= rd;
        slave_addr_in <= addr;
        reg_addr_in   <= reg_a;
        if (wr_queue.size() > 0)
            data_in <= wr_queue.pop_front();
        @(negedge I2C_Clk_In);
        start_in <= 1'b0;
        while (!done && cycles < TIMEOUT)
        begin
            @(posedge I2C_Clk_In);                      // Outputs settle mid-cycle
            cycles++;
            req_seen = data_req;
            if (data_req)
                req_count++;
            if (rd_valid)
            begin
                rd_queue.push_back(data_out);
                valid_count++;
            end
            done = !busy;
            @(negedge I2C_Clk_In);
            if (req_seen && wr_queue.size() > 0)
                data_in <= wr_queue.pop_front();        // Next byte after the load
        end
        if (!done)
        begin
            $display("Transfer to slave %0h timed out, busy still high after %0d cycles",
                     addr, TIMEOUT);
            errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic reset_state();
        int err0;
        err0 = errors;
        @(posedge I2C_Clk_In);
        check_value("busy", busy, 0);
        check_value("rd_valid", rd_valid, 0);
        check_value("data_req", data_req, 0);
        check_value("nack_error", nack_error, 0);
        check_value("sda_drive_low", sda_drive_low, 0);
        check_value("scl", scl, 1);
        report_test("reset state", err0);
    endtask

    task automatic single_write();
        int                    err0;
        i2c_master_pkg::byte_t value;
        err0  = errors;
        value = 8'($random(seed));
        wr_queue.push_back(value);
        run_transfer(1'b0, 1'b0, 2'd0, SLAVE_ADDR, 8'h12);
        check_value("slave reg 12", u_slave.regs[8'h12], value);
        check_value("data_req count", req_count, 1);
        check_value("rd_valid count", valid_count, 0);
        check_value("nack_error", nack_error, 0);
        report_test("single write", err0);
    endtask

    task automatic burst_write();
        int                    err0;
        i2c_master_pkg::byte_t values [4];
        err0 = errors;
        for (int i = 0; i < 4; i++)
        begin
            values[i] = 8'($random(seed));
            wr_queue.push_back(values[i]);
        end
        run_transfer(1'b0, 1'b1, 2'd3, SLAVE_ADDR, 8'h40);
        for (int i = 0; i < 4; i++)
            check_value($sformatf("slave reg %0h", 8'h40 + i), u_slave.regs[8'h40 + i],
                        values[i]);
        check_value("data_req count", req_count, 4);
        report_test("burst write", err0);
    endtask

    task automatic single_read();
        int                    err0;
        i2c_master_pkg::byte_t expected;
        err0     = errors;
        expected = u_slave.regs[8'h7a];
        run_transfer(1'b1, 1'b0, 2'd0, SLAVE_ADDR, 8'h7a);
        check_value("rd_valid count", valid_count, 1);
        check_value("data_req count", req_count, 0);
        if (rd_queue.size() > 0)
            check_value("data_out", rd_queue[0], expected);
        report_test("single read", err0);
    endtask

    task automatic burst_read();
        int err0;
        err0 = errors;
        run_transfer(1'b1, 1'b1, 2'd2, SLAVE_ADDR, 8'hc0);
        check_value("rd_valid count", valid_count, 3);
        for (int i = 0; i < rd_queue.size() && i < 3; i++)
            check_value("data_out", rd_queue[i], u_slave.regs[8'hc0 + i]);
        report_test("burst read", err0);
    endtask

    task automatic nack_abort();
        int                    err0;
        i2c_master_pkg::byte_t value;
        err0 = errors;
        run_transfer(1'b0, 1'b0, 2'd0, 7'h23, 8'h05);
        check_value("nack_error", nack_error, 1);
        check_value("data_req count", req_count, 0);
        check_value("rd_valid count", valid_count, 0);
        repeat (2) @(posedge I2C_Clk_In);
        check_value("nack_error", nack_error, 1);     // Sticky while idle
        value = 8'($random(seed));
        wr_queue.push_back(value);
        run_transfer(1'b0, 1'b0, 2'd0, SLAVE_ADDR, 8'h05);
        check_value("nack_error", nack_error, 0);
        check_value("slave reg 5", u_slave.regs[8'h05], value);
        report_test("nack abort", err0);
    endtask

    initial
    begin
        seed          = 32'h4579;
        errors        = 0;
        tests         = 0;
        Reset_In      = 1'b1;
        start_in      = 1'b0;
        burst_in      = 1'b0;
        burst_len_in  = '0;
        read_in       = 1'b0;
        slave_addr_in = '0;
        reg_addr_in   = '0;
        data_in       = '0;
        repeat (3) @(posedge I2C_Clk_In);
        @(negedge I2C_Clk_In);
        Reset_In <= 1'b0;
        reset_state();
        single_write();
        burst_write();
        single_read();
        burst_read();
        nack_abort();
        end_run();
    end

endmodule

`default_nettype wire

//--- bench/i2c_slave_model.sv
// Behavioral I2C slave
`timescale 1ns/1ns
`default_nettype none

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  wire  scl,
    input  wire  sda,
    output logic pull_low                               // Open-drain pull on SDA
);

    typedef enum {ph_idle, ph_addr, ph_reg, ph_wdata, ph_rdata} phase_t;

    i2c_master_pkg::byte_t regs [256];
    i2c_master_pkg::byte_t shreg;
    i2c_master_pkg::byte_t ptr;                         // Register pointer
    phase_t                phase;
    int                    bit_cnt;                     // SCL rises in the current byte
    logic                  rd_mode;
    logic                  master_ack;
    logic                  prev_scl;
    logic                  prev_sda;
    logic                  scl_now;
    logic                  sda_now;
    int                    seed;

    // ----------------------------------------------------------------------
    // Bit level actions
    // ----------------------------------------------------------------------
    task automatic scl_rise();
        if (phase == ph_rdata && bit_cnt == 8)
            master_ack = !sda_now;
        else if (phase != ph_rdata && bit_cnt < 8)
            shreg = {shreg[i2c_master_pkg::BYTE_W-2:0], sda_now};     // MSB first
        bit_cnt++;
    endtask

    task automatic scl_fall();
        if (bit_cnt == 8)
        begin
            pull_low = (phase != ph_rdata);             // ACK own address and bytes
            case (phase)
                ph_addr:
                begin
                    rd_mode = shreg[0];
                    if (shreg[7:1] != DEV_ADDR)
                    begin
                        phase    = ph_idle;             // Not ours so SDA stays released
                        pull_low = 1'b0;
                    end
                end
                ph_reg:
                    ptr = shreg;
                ph_wdata:
                begin
                    regs[ptr] = shreg;
                    ptr++;
                end
                default:
                    pull_low = 1'b0;                    // Master acks the read byte
            endcase
        end
        else if (bit_cnt == 9)
        begin
            bit_cnt  = 0;
            pull_low = 1'b0;
            case (phase)
                ph_addr:
                    phase = rd_mode ? ph_rdata : ph_reg;
                ph_reg:
                    phase = ph_wdata;
                ph_rdata:
                begin
                    ptr++;
                    if (!master_ack)
                        phase = ph_idle;                // NACK ends the read
                end
                default:
                    bit_cnt = 0;
            endcase
            if (phase == ph_rdata)
            begin
                shreg    = regs[ptr];
                pull_low = !shreg[7];
            end
        end
        else if (phase == ph_rdata && bit_cnt > 0)
            pull_low = !shreg[7 - bit_cnt];
    endtask

    // Bus edges between two samples
    task automatic sample_bus();
        scl_now = scl;
        sda_now = sda;
        if (prev_scl && scl_now && prev_sda && !sda_now)
        begin
            phase    = ph_addr;                         // Start or repeated start
            bit_cnt  = 0;
            pull_low = 1'b0;
        end
        else if (prev_scl && scl_now && !prev_sda && sda_now)
        begin
            phase    = ph_idle;                         // Stop
            pull_low = 1'b0;
        end
        else if (phase != ph_idle && !prev_scl && scl_now)
            scl_rise();
        else if (phase != ph_idle && prev_scl && !scl_now)
            scl_fall();
        prev_scl = scl_now;
        prev_sda = sda_now;
    endtask

    // Sampling at odd times keeps clear of clock edges
    initial
    begin
        seed       = 32'h4579;
        pull_low   = 1'b0;
        phase      = ph_idle;
        bit_cnt    = 0;
        rd_mode    = 1'b0;
        master_ack = 1'b0;
        shreg      = '0;
        ptr        = '0;
        prev_scl   = 1'b1;
        prev_sda   = 1'b1;
        for (int i = 0; i < 256; i++)
            regs[i] = 8'($random(seed));
        #1;
        forever
        begin
            sample_bus();
            #2;
        end
    end

endmodule

`default_nettype wire

//--- design/i2c_byte_rx.sv
// I2C byte receiver
`timescale 1ns/1ns
`default_nettype none

module i2c_byte_rx (
    input  wire                   I2C_Clk_In,
    input  wire                   Reset_In,
    input  wire                   rx_enable,    // High for the whole data phase
    input  wire                   sda_in,
    output i2c_master_pkg::byte_t rx_byte,      // Held until next enable
    output logic                  rx_done       // Eight samples taken
);

    logic [i2c_master_pkg::BIT_CNT_W-1:0] sample_cnt;

    // ----------------------------------------------------------------------
    // Sample counter cleared whenever the receiver is idle
    // ----------------------------------------------------------------------
    always_ff @(posedge I2C_Clk_In or posedge Reset_In)
    begin
        if (Reset_In)
        begin
            sample_cnt <= '0;
        end
        else if (!rx_enable)
        begin
            sample_cnt <= '0;
        end
        else if (!rx_done)
        begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    assign rx_done = (sample_cnt == i2c_master_pkg::BIT_CNT_W'(i2c_master_pkg::BYTE_W));

    // SDA is stable while SCL is high
    always_ff @(posedge I2C_Clk_In)
    begin
        if (rx_enable && !rx_done)
        begin
            rx_byte <= {rx_byte[i2c_master_pkg::BYTE_W-2:0], sda_in};   // MSB arrives first
        end
    end

endmodule

`default_nettype wire

//--- design/i2c_byte_tx.sv
// I2C byte transmitter
`timescale 1ns/1ns
`default_nettype none

module i2c_byte_tx (
    input  wire                   I2C_Clk_In,
    input  wire                   Reset_In,
    input  wire                   tx_load,      // Capture tx_byte, restart count
    input  wire                   tx_shift,     // Advance one bit per falling edge
    input  wire i2c_master_pkg::byte_t tx_byte,
    output logic                  tx_bit,       // Current bit, MSB first
    output logic                  tx_last       // Final bit of the byte on the line
);

    logic [i2c_master_pkg::BIT_CNT_W-1:0] bit_cnt;
    i2c_master_pkg::byte_t                shift_reg;

    // ----------------------------------------------------------------------
    // Bit counter
    // ----------------------------------------------------------------------
    always_ff @(negedge I2C_Clk_In or posedge Reset_In)
    begin
        if (Reset_In)
        begin
            bit_cnt <= '0;
        end
        else if (tx_load)
        begin
            bit_cnt <= i2c_master_pkg::BIT_CNT_W'(i2c_master_pkg::BYTE_W - 1);
        end
        else if (tx_shift && (bit_cnt != '0))
        begin
            bit_cnt <= bit_cnt - 1'b1;              // Stops at zero
        end
    end

    // ----------------------------------------------------------------------
    // Shift register
    // ----------------------------------------------------------------------
    always_ff @(negedge I2C_Clk_In)
    begin
        if (tx_load)
        begin
            shift_reg <= tx_byte;
        end
        else if (tx_shift)
        begin
            shift_reg <= {shift_reg[i2c_master_pkg::BYTE_W-2:0], 1'b0};
        end
    end

    assign tx_bit  = shift_reg[i2c_master_pkg::BYTE_W-1];
    assign tx_last = (bit_cnt == '0);

endmodule

`default_nettype wire

//--- design/i2c_master.sv
// I2C master top level
`timescale 1ns/1ns
`default_nettype none

module i2c_master (
    input  wire                                 I2C_Clk_In,
    input  wire                                 Reset_In,
    input  wire                                 start_in,      // One-cycle start pulse
    input  wire                                 burst_in,
    input  wire [i2c_master_pkg::BURST_W-1:0]   burst_len_in,  // Bytes minus one
    input  wire                                 read_in,
    input  wire [i2c_master_pkg::ADDR_W-1:0]    slave_addr_in,
    input  wire i2c_master_pkg::byte_t          reg_addr_in,
    input  wire i2c_master_pkg::byte_t          data_in,
    output logic                                busy,
    output logic                                data_req,      // Write byte taken
    output i2c_master_pkg::byte_t               data_out,
    output logic                                rd_valid,
    output logic                                nack_error,    // Sticky until next start
    input  wire                                 sda_in,
    output logic                                sda_drive_low,
    output logic                                scl
);

    logic                  tx_load;
    logic                  tx_shift;
    i2c_master_pkg::byte_t tx_byte;
    logic                  tx_bit;
    logic                  tx_last;
    logic                  rx_enable;
    i2c_master_pkg::byte_t rx_byte;
    logic                  rx_done;
    logic                  scl_enable;

    // ----------------------------------------------------------------------
    // Byte engines
    // ----------------------------------------------------------------------
    i2c_byte_tx u_byte_tx (
        .I2C_Clk_In (I2C_Clk_In),
        .Reset_In   (Reset_In),
        .tx_load    (tx_load),
        .tx_shift   (tx_shift),
        .tx_byte    (tx_byte),
        .tx_bit     (tx_bit),
        .tx_last    (tx_last)
    );

    i2c_byte_rx u_byte_rx (
        .I2C_Clk_In (I2C_Clk_In),
        .Reset_In   (Reset_In),
        .rx_enable  (rx_enable),
        .sda_in     (sda_in),
        .rx_byte    (rx_byte),
        .rx_done    (rx_done)
    );

    i2c_transfer_seq u_transfer_seq (
        .I2C_Clk_In    (I2C_Clk_In),
        .Reset_In      (Reset_In),
        .start_in      (start_in),
        .burst_in      (burst_in),
        .burst_len_in  (burst_len_in),
        .read_in       (read_in),
        .slave_addr_in (slave_addr_in),
        .reg_addr_in   (reg_addr_in),
        .data_in       (data_in),
        .sda_in        (sda_in),
        .tx_bit        (tx_bit),
        .tx_last       (tx_last),
        .rx_byte       (rx_byte),
        .rx_done       (rx_done),
        .tx_load       (tx_load),
        .tx_shift      (tx_shift),
        .tx_byte       (tx_byte),
        .rx_enable     (rx_enable),
        .sda_drive_low (sda_drive_low),
        .scl_enable    (scl_enable),
        .busy          (busy),
        .data_req      (data_req),
        .data_out      (data_out),
        .rd_valid      (rd_valid),
        .nack_error    (nack_error)
    );

    // SCL parks high outside the clocked phases
    assign scl = scl_enable ? I2C_Clk_In : 1'b1;

endmodule

`default_nettype wire

//--- design/i2c_master_pkg.sv
// I2C master shared definitions
`default_nettype none

package i2c_master_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int BYTE_W    = 8;               // Data byte
    localparam int ADDR_W    = 7;               // Slave device address
    localparam int BURST_W   = 2;               // Burst length field for up to 4 bytes
    localparam int BIT_CNT_W = 4;               // Bit counter reaching BYTE_W

    typedef logic [BYTE_W-1:0] byte_t;

    // ----------------------------------------------------------------------
    // Transfer phases
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        st_idle,                                // Bus released and SCL high
        st_start,                               // SDA falls while SCL high
        st_slave_write_inst,                    // Address with write bit
        st_inst_ack,
        st_reg_addr,                            // Register address byte
        st_reg_ack,
        st_write_data,
        st_data_ack,
        st_restart_stop,                        // Hold SDA low before restart
        st_restart_start,
        st_slave_read_inst,                     // Address with read bit
        st_read_inst_ack,
        st_read_data,
        st_read_ack,                            // Master ACK when more bytes follow
        st_read_nack,                           // Master NACK on last byte
        st_stop
    } seq_state_t;

endpackage

`default_nettype wire

//--- design/i2c_transfer_seq.sv
// I2C transfer sequencer
`timescale 1ns/1ns
`default_nettype none

module i2c_transfer_seq (
    input  wire                                     I2C_Clk_In,
    input  wire                                     Reset_In,
    input  wire                                     start_in,
    input  wire                                     burst_in,
    input  wire [i2c_master_pkg::BURST_W-1:0]       burst_len_in,
    input  wire                                     read_in,
    input  wire [i2c_master_pkg::ADDR_W-1:0]        slave_addr_in,
    input  wire i2c_master_pkg::byte_t              reg_addr_in,
    input  wire i2c_master_pkg::byte_t              data_in,
    input  wire                                     sda_in,
    input  wire                                     tx_bit,
    input  wire                                     tx_last,
    input  wire i2c_master_pkg::byte_t              rx_byte,
    input  wire                                     rx_done,
    output logic                                    tx_load,
    output logic                                    tx_shift,
    output i2c_master_pkg::byte_t                   tx_byte,
    output logic                                    rx_enable,
    output logic                                    sda_drive_low,
    output logic                                    scl_enable,
    output logic                                    busy,
    output logic                                    data_req,
    output i2c_master_pkg::byte_t                   data_out,
    output logic                                    rd_valid,
    output logic                                    nack_error
);

    i2c_master_pkg::seq_state_t          state;
    i2c_master_pkg::seq_state_t          state_nxt;
    logic [i2c_master_pkg::ADDR_W-1:0]   slave_addr_q;
    i2c_master_pkg::byte_t               reg_addr_q;
    logic                                read_q;
    logic [i2c_master_pkg::BURST_W-1:0]  bytes_left;   // Bytes after the current one
    logic                                ack_low;      // SDA low at last rising edge
    logic                                ack_check;

    // ----------------------------------------------------------------------
    // Acknowledge sampling on the high clock phase
    // ----------------------------------------------------------------------
    always_ff @(posedge I2C_Clk_In or posedge Reset_In)
    begin
        if (Reset_In)
            ack_low <= 1'b0;
        else
            ack_low <= ~sda_in;
    end

    assign ack_check = state inside {i2c_master_pkg::st_inst_ack, i2c_master_pkg::st_reg_ack,
                                     i2c_master_pkg::st_data_ack,
                                     i2c_master_pkg::st_read_inst_ack};

    // ----------------------------------------------------------------------
    // Next phase
    // ----------------------------------------------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            i2c_master_pkg::st_idle:
                if (start_in)
                    state_nxt = i2c_master_pkg::st_start;
            i2c_master_pkg::st_start:
                state_nxt = i2c_master_pkg::st_slave_write_inst;
            i2c_master_pkg::st_slave_write_inst:
                if (tx_last)
                    state_nxt = i2c_master_pkg::st_inst_ack;
            i2c_master_pkg::st_inst_ack:
                state_nxt = ack_low ? i2c_master_pkg::st_reg_addr : i2c_master_pkg::st_stop;
            i2c_master_pkg::st_reg_addr:
                if (tx_last)
                    state_nxt = i2c_master_pkg::st_reg_ack;
            i2c_master_pkg::st_reg_ack:
                if (!ack_low)
                    state_nxt = i2c_master_pkg::st_stop;
                else if (read_q)
                    state_nxt = i2c_master_pkg::st_restart_stop;
                else
                    state_nxt = i2c_master_pkg::st_write_data;
            i2c_master_pkg::st_write_data:
                if (tx_last)
                    state_nxt = i2c_master_pkg::st_data_ack;
            i2c_master_pkg::st_data_ack:
                if (ack_low && (bytes_left != '0))
                    state_nxt = i2c_master_pkg::st_write_data;
                else
                    state_nxt = i2c_master_pkg::st_stop;
            i2c_master_pkg::st_restart_stop:
                state_nxt = i2c_master_pkg::st_restart_start;
            i2c_master_pkg::st_restart_start:
                state_nxt = i2c_master_pkg::st_slave_read_inst;
            i2c_master_pkg::st_slave_read_inst:
                if (tx_last)
                    state_nxt = i2c_master_pkg::st_read_inst_ack;
            i2c_master_pkg::st_read_inst_ack:
                state_nxt = ack_low ? i2c_master_pkg::st_read_data : i2c_master_pkg::st_stop;
            i2c_master_pkg::st_read_data:
                if (rx_done)
                    state_nxt = (bytes_left == '0) ? i2c_master_pkg::st_read_nack
                                                   : i2c_master_pkg::st_read_ack;
            i2c_master_pkg::st_read_ack:
                state_nxt = i2c_master_pkg::st_read_data;
            i2c_master_pkg::st_read_nack:
                state_nxt = i2c_master_pkg::st_stop;
            default:
                state_nxt = i2c_master_pkg::st_idle;        // Stop ends in idle
        endcase
    end

    // ----------------------------------------------------------------------
    // Phase register, burst count and error flag
    // ----------------------------------------------------------------------
    always_ff @(negedge I2C_Clk_In or posedge Reset_In)
    begin
        if (Reset_In)
        begin
            state      <= i2c_master_pkg::st_idle;
            read_q     <= 1'b0;
            bytes_left <= '0;
            nack_error <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (state == i2c_master_pkg::st_start)
            begin
                read_q     <= read_in;
                bytes_left <= burst_in ? burst_len_in : '0;
            end
            else if ((state == i2c_master_pkg::st_read_ack) ||
                     (state_nxt == i2c_master_pkg::st_write_data &&
                      state == i2c_master_pkg::st_data_ack))
            begin
                bytes_left <= bytes_left - 1'b1;
            end

            if ((state == i2c_master_pkg::st_idle) && start_in)
                nack_error <= 1'b0;
            else if (ack_check && !ack_low)
                nack_error <= 1'b1;
        end
    end

    // Addresses for the register and restart phases
    always_ff @(negedge I2C_Clk_In)
    begin
        if (state == i2c_master_pkg::st_start)
        begin
            slave_addr_q <= slave_addr_in;
            reg_addr_q   <= reg_addr_in;
        end
    end

    // ----------------------------------------------------------------------
    // Transmitter loading and write data requests
    // ----------------------------------------------------------------------
    always_comb
    begin
        tx_load  = 1'b0;
        data_req = 1'b0;
        tx_byte  = reg_addr_q;
        case (state)
            i2c_master_pkg::st_start:
            begin
                tx_load = 1'b1;
                tx_byte = {slave_addr_in, 1'b0};            // Write instruction
            end
            i2c_master_pkg::st_inst_ack:
                tx_load = 1'b1;
            i2c_master_pkg::st_reg_ack, i2c_master_pkg::st_data_ack:
                if (!read_q && (state == i2c_master_pkg::st_reg_ack || bytes_left != '0))
                begin
                    tx_load  = 1'b1;
                    data_req = 1'b1;
                    tx_byte  = data_in;
                end
            i2c_master_pkg::st_restart_start:
            begin
                tx_load = 1'b1;
                tx_byte = {slave_addr_q, 1'b1};             // Read instruction
            end
            default:
                tx_load = 1'b0;
        endcase
    end

    assign tx_shift = state inside {i2c_master_pkg::st_slave_write_inst,
                                    i2c_master_pkg::st_reg_addr,
                                    i2c_master_pkg::st_write_data,
                                    i2c_master_pkg::st_slave_read_inst};

    // ----------------------------------------------------------------------
    // SDA pull-low from conditions, transmitter bits and master ACK
    // ----------------------------------------------------------------------
    always_comb
    begin
        case (state)
            i2c_master_pkg::st_start, i2c_master_pkg::st_restart_start:
                sda_drive_low = I2C_Clk_In;                 // Falls in the high half
            i2c_master_pkg::st_restart_stop, i2c_master_pkg::st_stop,
            i2c_master_pkg::st_read_ack:
                sda_drive_low = 1'b1;
            default:
                sda_drive_low = tx_shift && !tx_bit;
        endcase
    end

    assign scl_enable = !(state inside {i2c_master_pkg::st_idle, i2c_master_pkg::st_start,
                                        i2c_master_pkg::st_restart_start});
    assign busy       = (state != i2c_master_pkg::st_idle);
    assign rx_enable  = (state == i2c_master_pkg::st_read_data);
    assign rd_valid   = state inside {i2c_master_pkg::st_read_ack, i2c_master_pkg::st_read_nack};
    assign data_out   = rx_byte;                            // Held through the ack cycle

endmodule

`default_nettype wire

//--- sim.f
design/i2c_master_pkg.sv
design/i2c_byte_tx.sv
design/i2c_byte_rx.sv
design/i2c_transfer_seq.sv
design/i2c_master.sv
bench/i2c_slave_model.sv
bench/i2c_master_tb.sv
